//--- src.f
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_decoder.sv
design/bus_config_regs.sv
design/bus_memory.sv
design/bus_subsystem_top.sv
testbench/bus_properties.sv
testbench/tb_bus_subsystem.sv

//--- Makefile
TOP := tb_bus_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

//--- testbench/tb_bus_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem;

	// bit 31 selects the config block, offsets 0 and 4
	localparam logic [31:0] cfg_prio = 32'h8000_0000;
	localparam logic [31:0] cfg_wait = 32'h8000_0004;
	localparam int n_random = 24;
	// roughly 130 transfers of under ten cycles each, with margin
	localparam int max_cycles = 2000;

	logic        i_clk;
	logic        i_rst;
	logic        i_bus_en1;
	logic        i_wr_rd1;
	logic [31:0] i_wr_data1;
	logic [31:0] i_addr1;
	logic [2:0]  i_size1;
	logic        o_ack1;
	logic [31:0] o_rd_data1;
	logic        i_bus_en2;
	logic        i_wr_rd2;
	logic [31:0] i_wr_data2;
	logic [31:0] i_addr2;
	logic [2:0]  i_size2;
	logic        o_ack2;
	logic [31:0] o_rd_data2;

	// expected memory contents
	logic [31:0] model [bus_pkg::mem_words];
	int          cycle_count = 0;
	int          err_count = 0;
	integer      seed;

	bus_subsystem_top u_dut (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_bus_en1 (i_bus_en1),
		.i_wr_rd1  (i_wr_rd1),
		.i_wr_data1(i_wr_data1),
		.i_addr1   (i_addr1),
		.i_size1   (i_size1),
		.o_ack1    (o_ack1),
		.o_rd_data1(o_rd_data1),
		.i_bus_en2 (i_bus_en2),
		.i_wr_rd2  (i_wr_rd2),
		.i_wr_data2(i_wr_data2),
		.i_addr2   (i_addr2),
		.i_size2   (i_size2),
		.o_ack2    (o_ack2),
		.o_rd_data2(o_rd_data2)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("Something failed");
			$fatal(1, "simulation timeout");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			err_count++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "check %s mismatched", name);
		end
	endtask

	task automatic bus_start1(input logic wr, input logic [31:0] addr,
			input logic [31:0] data, input logic [2:0] size);
		@(posedge i_clk);
		i_bus_en1  <= 1'b1;
		i_wr_rd1   <= wr;
		i_wr_data1 <= data;
		i_addr1    <= addr;
		i_size1    <= size;
	endtask

	task automatic bus_start2(input logic wr, input logic [31:0] addr,
			input logic [31:0] data, input logic [2:0] size);
		@(posedge i_clk);
		i_bus_en2  <= 1'b1;
		i_wr_rd2   <= wr;
		i_wr_data2 <= data;
		i_addr2    <= addr;
		i_size2    <= size;
	endtask

	// latency counts the edges after enable rose that still saw ack low
	task automatic bus_finish1(output logic [31:0] rd_data, output int latency);
		latency = 0;
		@(posedge i_clk);
		while (!o_ack1) begin
			latency++;
			@(posedge i_clk);
		end
		rd_data = o_rd_data1;
		i_bus_en1 <= 1'b0;
		do begin
			@(posedge i_clk);
		end while (o_ack1);
	endtask

	task automatic bus_finish2(output logic [31:0] rd_data, output int latency);
		latency = 0;
		@(posedge i_clk);
		while (!o_ack2) begin
			latency++;
			@(posedge i_clk);
		end
		rd_data = o_rd_data2;
		i_bus_en2 <= 1'b0;
		do begin
			@(posedge i_clk);
		end while (o_ack2);
	endtask

	task automatic bus_write1(input logic [31:0] addr, input logic [31:0] data,
			input logic [2:0] size, output int latency);
		logic [31:0] ignored;
		bus_start1(1'b1, addr, data, size);
		bus_finish1(ignored, latency);
	endtask

	task automatic bus_write2(input logic [31:0] addr, input logic [31:0] data,
			input logic [2:0] size, output int latency);
		logic [31:0] ignored;
		bus_start2(1'b1, addr, data, size);
		bus_finish2(ignored, latency);
	endtask

	task automatic bus_read1(input logic [31:0] addr, output logic [31:0] data,
			output int latency);
		bus_start1(1'b0, addr, 32'h0, bus_pkg::size_word);
		bus_finish1(data, latency);
	endtask

	task automatic bus_read2(input logic [31:0] addr, output logic [31:0] data,
			output int latency);
		bus_start2(1'b0, addr, 32'h0, bus_pkg::size_word);
		bus_finish2(data, latency);
	endtask

	// byte lane n carries data bits 8n+7:8n
	function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [2:0] size);
		logic [7:0] idx;
		int         lane;
		idx = addr[9:2];
		case (size)
			bus_pkg::size_byte: begin
				lane = int'(addr[1:0]);
				model[idx][8*lane +: 8] = data[8*lane +: 8];
			end
			bus_pkg::size_half: begin
				lane = addr[1] ? 2 : 0;
				model[idx][8*lane +: 16] = data[8*lane +: 16];
			end
			default: model[idx] = data;
		endcase
	endfunction

	task automatic reset_and_basic();
		logic [31:0] rd;
		int          lat;
		check_value("reset ack1", 32'h0, 32'(o_ack1));
		check_value("reset ack2", 32'h0, 32'(o_ack2));
		bus_read1(cfg_prio, rd, lat);
		check_value("reset prio mode", 32'(bus_pkg::prio_port2), rd);
		bus_read2(cfg_wait, rd, lat);
		check_value("reset wait count", 32'h0, rd);
		bus_write1(32'h10, 32'hCAFE_0001, bus_pkg::size_word, lat);
		bus_read1(32'h10, rd, lat);
		check_value("port 1 word", 32'hCAFE_0001, rd);
		bus_write2(32'h24, 32'h5EED_0002, bus_pkg::size_word, lat);
		bus_read2(32'h24, rd, lat);
		check_value("port 2 word", 32'h5EED_0002, rd);
	endtask

	task automatic lane_write_check(input string name, input logic [31:0] addr,
			input logic [31:0] data, input logic [2:0] size, input logic [31:0] expected);
		logic [31:0] rd;
		int          lat;
		bus_write1(addr, data, size, lat);
		bus_read2(addr & 32'hFFFF_FFFC, rd, lat);
		check_value(name, expected, rd);
	endtask

	task automatic byte_lanes();
		lane_write_check("lane base", 32'h40, 32'h1122_3344, bus_pkg::size_word, 32'h1122_3344);
		lane_write_check("byte lane 0", 32'h40, 32'hFFFF_FFA5, bus_pkg::size_byte, 32'h1122_33A5);
		lane_write_check("byte lane 1", 32'h41, 32'hEEEE_5AEE, bus_pkg::size_byte, 32'h1122_5AA5);
		lane_write_check("byte lane 2", 32'h42, 32'hDDC3_DDDD, bus_pkg::size_byte, 32'h11C3_5AA5);
		lane_write_check("byte lane 3", 32'h43, 32'h7ECC_CCCC, bus_pkg::size_byte, 32'h7EC3_5AA5);
		lane_write_check("half base", 32'h44, 32'hDEAD_BEEF, bus_pkg::size_word, 32'hDEAD_BEEF);
		lane_write_check("half low", 32'h44, 32'h9999_1234, bus_pkg::size_half, 32'hDEAD_1234);
		lane_write_check("half high", 32'h46, 32'h5678_ABCD, bus_pkg::size_half, 32'h5678_1234);
	endtask

	task automatic wait_state_latency();
		int          waits [3] = '{0, 3, 7};
		logic [31:0] rd;
		int          lat;
		foreach (waits[k]) begin
			bus_write2(cfg_wait, waits[k], bus_pkg::size_word, lat);
			bus_read1(32'h80, rd, lat);
			check_value($sformatf("memory latency, wait %0d", waits[k]), waits[k] + 2, lat);
			bus_read1(cfg_wait, rd, lat);
			check_value($sformatf("config latency, wait %0d", waits[k]), 2, lat);
			check_value($sformatf("wait readback %0d", waits[k]), waits[k], rd);
		end
		bus_write2(cfg_wait, 32'd1, bus_pkg::size_word, lat);
	endtask

	task automatic priority_race(input string name, input logic [1:0] mode,
			input int expected_first);
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] rd;
		int          lat;
		int          lat1;
		int          lat2;
		int          first;
		bus_write1(cfg_prio, 32'(mode), bus_pkg::size_word, lat);
		fork
			bus_start1(1'b1, 32'h100, 32'hAAAA_1111, bus_pkg::size_word);
			bus_start2(1'b1, 32'h100, 32'hBBBB_2222, bus_pkg::size_word);
		join
		fork
			bus_finish1(rd1, lat1);
			bus_finish2(rd2, lat2);
		join
		first = (lat1 < lat2) ? 1 : 2;
		check_value({name, " first ack"}, expected_first, first);
		bus_read1(32'h100, rd, lat);
		// the port granted second leaves its value
		check_value({name, " surviving data"},
			(expected_first == 1) ? 32'hBBBB_2222 : 32'hAAAA_1111, rd);
	endtask

	task automatic round_robin_rounds();
		logic [31:0] rd;
		int          lat;
		int          lat1;
		int          lat2;
		int          first;
		int          expected_first;
		int          last;
		bus_write2(cfg_prio, 32'(bus_pkg::prio_round_robin), bus_pkg::size_word, lat);
		last = 2;
		for (int round = 0; round < 3; round++) begin
			expected_first = (last == 2) ? 1 : 2;
			fork
				bus_start1(1'b0, 32'h10, 32'h0, bus_pkg::size_word);
				bus_start2(1'b0, 32'h24, 32'h0, bus_pkg::size_word);
			join
			fork
				bus_finish1(rd, lat1);
				bus_finish2(rd, lat2);
			join
			first = (lat1 < lat2) ? 1 : 2;
			check_value($sformatf("round robin round %0d", round), expected_first, first);
			// a lone access by the first winner takes the last grant back
			if (first == 1) begin
				bus_read1(32'h10, rd, lat);
			end else begin
				bus_read2(32'h24, rd, lat);
			end
			last = first;
		end
	endtask

	task automatic random_traffic();
		logic [31:0] wr_addr [$];
		int          wr_port [$];
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] addr_b;
		logic [31:0] data;
		logic [31:0] data_b;
		logic [31:0] rd;
		int          lat;
		for (int i = 0; i < n_random; i++) begin
			r    = $random(seed);
			addr = {22'b0, r[7:0], 2'b00};
			data = $random(seed);
			if (i % 4 == 3) begin
				addr_b = {22'b0, r[7:0] + 8'd1, 2'b00};
				data_b = $random(seed);
				fork
					bus_start1(1'b1, addr, data, bus_pkg::size_word);
					bus_start2(1'b1, addr_b, data_b, bus_pkg::size_word);
				join
				fork
					bus_finish1(rd, lat);
					bus_finish2(rd, lat);
				join
				model_write(addr, data, bus_pkg::size_word);
				model_write(addr_b, data_b, bus_pkg::size_word);
				wr_addr.push_back(addr);
				wr_port.push_back(1);
				wr_addr.push_back(addr_b);
				wr_port.push_back(2);
			end else if (i % 2 == 0) begin
				bus_write1(addr, data, bus_pkg::size_word, lat);
				model_write(addr, data, bus_pkg::size_word);
				wr_addr.push_back(addr);
				wr_port.push_back(1);
			end else begin
				bus_write2(addr, data, bus_pkg::size_word, lat);
				model_write(addr, data, bus_pkg::size_word);
				wr_addr.push_back(addr);
				wr_port.push_back(2);
			end
		end
		foreach (wr_addr[k]) begin
			if (wr_port[k] == 1) begin
				bus_read2(wr_addr[k], rd, lat);
			end else begin
				bus_read1(wr_addr[k], rd, lat);
			end
			check_value($sformatf("random readback %h", wr_addr[k]),
				model[wr_addr[k][9:2]], rd);
		end
	endtask

	initial begin
		seed = 32'he11d7bee;
		i_rst      <= 1'b0;
		i_bus_en1  <= 1'b0;
		i_wr_rd1   <= 1'b0;
		i_wr_data1 <= 32'h0;
		i_addr1    <= 32'h0;
		i_size1    <= 3'd0;
		i_bus_en2  <= 1'b0;
		i_wr_rd2   <= 1'b0;
		i_wr_data2 <= 32'h0;
		i_addr2    <= 32'h0;
		i_size2    <= 3'd0;
		repeat (4) @(posedge i_clk);
		i_rst <= 1'b1;

		reset_and_basic();
		byte_lanes();
		wait_state_latency();
		priority_race("prio port 2", bus_pkg::prio_port2, 2);
		priority_race("prio port 1", bus_pkg::prio_port1, 1);
		round_robin_rounds();
		random_traffic();

		if (err_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "%0d checks mismatched", err_count);
		end
	end

endmodule

`default_nettype wire

//--- testbench/bus_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bus_properties (
	input logic       i_clk,
	input logic       i_rst,
	input logic       i_ack1,
	input logic       i_ack2,
	input logic       i_bus_en,
	input logic [1:0] i_state
);

	// grant machine encodings
	localparam logic [1:0] st_idle   = 2'b00;
	localparam logic [1:0] st_grant1 = 2'b01;
	localparam logic [1:0] st_grant2 = 2'b10;

	a_single_ack: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(i_ack1 && i_ack2))
		else $error("both master acknowledges high together");

	a_ack1_granted: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_ack1 |-> (i_state == st_grant1))
		else $error("port 1 acknowledged without its grant");

	a_ack2_granted: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_ack2 |-> (i_state == st_grant2))
		else $error("port 2 acknowledged without its grant");

	a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_state == st_idle) |-> !i_bus_en)
		else $error("shared enable high while arbiter idle");

endmodule

bind bus_arbiter bus_properties u_properties (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_ack1  (o_ack1),
	.i_ack2  (o_ack2),
	.i_bus_en(o_bus_en),
	.i_state (state)
);

`default_nettype wire

//--- design/bus_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem_top (
	input  logic                       i_clk,
	input  logic                       i_rst,

	input  logic                       i_bus_en1,
	input  logic                       i_wr_rd1,
	input  logic [bus_pkg::data_w-1:0] i_wr_data1,
	input  logic [bus_pkg::data_w-1:0] i_addr1,
	input  logic [bus_pkg::size_w-1:0] i_size1,
	output logic                       o_ack1,
	output logic [bus_pkg::data_w-1:0] o_rd_data1,

	input  logic                       i_bus_en2,
	input  logic                       i_wr_rd2,
	input  logic [bus_pkg::data_w-1:0] i_wr_data2,
	input  logic [bus_pkg::data_w-1:0] i_addr2,
	input  logic [bus_pkg::size_w-1:0] i_size2,
	output logic                       o_ack2,
	output logic [bus_pkg::data_w-1:0] o_rd_data2
);

	// shared bus after the arbiter
	logic                       bus_en;
	logic                       bus_wr_rd;
	logic [bus_pkg::data_w-1:0] bus_wr_data;
	logic [bus_pkg::data_w-1:0] bus_addr;
	logic [bus_pkg::size_w-1:0] bus_size;
	logic                       bus_ack;
	logic [bus_pkg::data_w-1:0] bus_rd_data;

	logic                       mem_en;
	logic                       mem_ack;
	logic [bus_pkg::data_w-1:0] mem_rd_data;
	logic                       cfg_en;
	logic                       cfg_ack;
	logic [bus_pkg::data_w-1:0] cfg_rd_data;

	logic [bus_pkg::prio_w-1:0] prio_mode;
	logic [bus_pkg::wait_w-1:0] wait_cycles;

	bus_arbiter u_arbiter (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_prio_mode(prio_mode),
		.i_bus_en1  (i_bus_en1),
		.i_wr_rd1   (i_wr_rd1),
		.i_wr_data1 (i_wr_data1),
		.i_addr1    (i_addr1),
		.i_size1    (i_size1),
		.o_ack1     (o_ack1),
		.o_rd_data1 (o_rd_data1),
		.i_bus_en2  (i_bus_en2),
		.i_wr_rd2   (i_wr_rd2),
		.i_wr_data2 (i_wr_data2),
		.i_addr2    (i_addr2),
		.i_size2    (i_size2),
		.o_ack2     (o_ack2),
		.o_rd_data2 (o_rd_data2),
		.i_ack      (bus_ack),
		.i_rd_data  (bus_rd_data),
		.o_bus_en   (bus_en),
		.o_wr_rd    (bus_wr_rd),
		.o_wr_data  (bus_wr_data),
		.o_addr     (bus_addr),
		.o_size     (bus_size)
	);

	bus_decoder u_decoder (
		.i_bus_en     (bus_en),
		.i_addr       (bus_addr),
		.i_mem_ack    (mem_ack),
		.i_mem_rd_data(mem_rd_data),
		.i_cfg_ack    (cfg_ack),
		.i_cfg_rd_data(cfg_rd_data),
		.o_mem_en     (mem_en),
		.o_cfg_en     (cfg_en),
		.o_ack        (bus_ack),
		.o_rd_data    (bus_rd_data)
	);

	bus_config_regs u_config_regs (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_bus_en     (cfg_en),
		.i_wr_rd      (bus_wr_rd),
		.i_wr_data    (bus_wr_data),
		.i_addr       (bus_addr),
		.o_ack        (cfg_ack),
		.o_rd_data    (cfg_rd_data),
		.o_prio_mode  (prio_mode),
		.o_wait_cycles(wait_cycles)
	);

	bus_memory u_memory (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_bus_en     (mem_en),
		.i_wr_rd      (bus_wr_rd),
		.i_wr_data    (bus_wr_data),
		.i_addr       (bus_addr),
		.i_size       (bus_size),
		.i_wait_cycles(wait_cycles),
		.o_ack        (mem_ack),
		.o_rd_data    (mem_rd_data)
	);

endmodule

`default_nettype wire

//--- design/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_bus_en,
	input  logic                       i_wr_rd,
	input  logic [bus_pkg::data_w-1:0] i_wr_data,
	input  logic [bus_pkg::data_w-1:0] i_addr,
	input  logic [bus_pkg::size_w-1:0] i_size,
	input  logic [bus_pkg::wait_w-1:0] i_wait_cycles,
	output logic                       o_ack,
	output logic [bus_pkg::data_w-1:0] o_rd_data
);

	logic [bus_pkg::data_w-1:0]    mem [bus_pkg::mem_words];
	logic [bus_pkg::wait_w-1:0]    wait_cnt;
	logic [bus_pkg::mem_idx_w-1:0] word_idx;
	logic [bus_pkg::lanes-1:0]     lane_mask;
	logic                          pending;
	logic                          do_access;

	assign word_idx  = i_addr[bus_pkg::mem_idx_w+1:2];
	assign pending   = i_bus_en && !o_ack;
	assign do_access = pending && (wait_cnt == i_wait_cycles);

	// byte lanes touched by a write
	always_comb begin
		case (i_size)
			bus_pkg::size_byte:
				lane_mask = {{(bus_pkg::lanes-1){1'b0}}, 1'b1} << i_addr[1:0];
			bus_pkg::size_half:
				lane_mask = {{(bus_pkg::lanes-2){1'b0}}, 2'b11} << {i_addr[1], 1'b0};
			default:
				lane_mask = '1;
		endcase
	end

	// wait counter runs while the request is pending
	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			o_ack    <= 1'b0;
			wait_cnt <= '0;
		end else if (do_access) begin
			o_ack    <= 1'b1;
			wait_cnt <= '0;
		end else if (pending) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else if (!i_bus_en) begin
			o_ack <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_access) begin
			if (i_wr_rd) begin
				for (int b = 0; b < bus_pkg::lanes; b++) begin
					if (lane_mask[b]) begin
						mem[word_idx][8*b +: 8] <= i_wr_data[8*b +: 8];
					end
				end
			end else begin
				o_rd_data <= mem[word_idx];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/bus_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bus_config_regs (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_bus_en,
	input  logic                       i_wr_rd,
	input  logic [bus_pkg::data_w-1:0] i_wr_data,
	input  logic [bus_pkg::data_w-1:0] i_addr,
	output logic                       o_ack,
	output logic [bus_pkg::data_w-1:0] o_rd_data,
	output logic [bus_pkg::prio_w-1:0] o_prio_mode,
	output logic [bus_pkg::wait_w-1:0] o_wait_cycles
);

	logic [bus_pkg::cfg_sel_bit-1:0] offset;
	logic                            access;
	logic                            hit_prio;
	logic                            hit_wait;

	assign offset   = i_addr[bus_pkg::cfg_sel_bit-1:0];
	assign access   = i_bus_en && !o_ack;
	assign hit_prio = (offset == bus_pkg::cfg_prio_addr);
	assign hit_wait = (offset == bus_pkg::cfg_wait_addr);

	// ack one cycle after enable, dropped once enable is gone
	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			o_ack         <= 1'b0;
			o_prio_mode   <= bus_pkg::prio_port2;
			o_wait_cycles <= bus_pkg::wait_reset;
		end else if (access) begin
			o_ack <= 1'b1;
			if (i_wr_rd && hit_prio) begin
				o_prio_mode <= i_wr_data[bus_pkg::prio_w-1:0];
			end
			if (i_wr_rd && hit_wait) begin
				o_wait_cycles <= i_wr_data[bus_pkg::wait_w-1:0];
			end
		end else if (!i_bus_en) begin
			o_ack <= 1'b0;
		end
	end

	// read path, unmapped offsets return zero
	always_ff @(posedge i_clk) begin
		if (access && !i_wr_rd) begin
			if (hit_prio) begin
				o_rd_data <= {{(bus_pkg::data_w-bus_pkg::prio_w){1'b0}}, o_prio_mode};
			end else if (hit_wait) begin
				o_rd_data <= {{(bus_pkg::data_w-bus_pkg::wait_w){1'b0}}, o_wait_cycles};
			end else begin
				o_rd_data <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  logic                       i_bus_en,
	input  logic [bus_pkg::data_w-1:0] i_addr,
	input  logic                       i_mem_ack,
	input  logic [bus_pkg::data_w-1:0] i_mem_rd_data,
	input  logic                       i_cfg_ack,
	input  logic [bus_pkg::data_w-1:0] i_cfg_rd_data,
	output logic                       o_mem_en,
	output logic                       o_cfg_en,
	output logic                       o_ack,
	output logic [bus_pkg::data_w-1:0] o_rd_data
);

	logic cfg_sel;

	assign cfg_sel = i_addr[bus_pkg::cfg_sel_bit];

	// only the addressed slave sees enable
	assign o_mem_en = i_bus_en && !cfg_sel;
	assign o_cfg_en = i_bus_en && cfg_sel;

	always_comb begin
		if (cfg_sel) begin
			o_ack     = i_cfg_ack;
			o_rd_data = i_cfg_rd_data;
		end else begin
			o_ack     = i_mem_ack;
			o_rd_data = i_mem_rd_data;
		end
	end

endmodule

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic [bus_pkg::prio_w-1:0]        i_prio_mode,

	input  logic                              i_bus_en1,
	input  logic                              i_wr_rd1,
	input  logic [bus_pkg::data_w-1:0]        i_wr_data1,
	input  logic [bus_pkg::data_w-1:0]        i_addr1,
	input  logic [bus_pkg::size_w-1:0]        i_size1,
	output logic                              o_ack1,
	output logic [bus_pkg::data_w-1:0]        o_rd_data1,

	input  logic                              i_bus_en2,
	input  logic                              i_wr_rd2,
	input  logic [bus_pkg::data_w-1:0]        i_wr_data2,
	input  logic [bus_pkg::data_w-1:0]        i_addr2,
	input  logic [bus_pkg::size_w-1:0]        i_size2,
	output logic                              o_ack2,
	output logic [bus_pkg::data_w-1:0]        o_rd_data2,

	input  logic                              i_ack,
	input  logic [bus_pkg::data_w-1:0]        i_rd_data,
	output logic                              o_bus_en,
	output logic                              o_wr_rd,
	output logic [bus_pkg::data_w-1:0]        o_wr_data,
	output logic [bus_pkg::data_w-1:0]        o_addr,
	output logic [bus_pkg::size_w-1:0]        o_size
);

	typedef enum logic [1:0] {
		st_idle   = 2'b00,
		st_grant1 = 2'b01,
		st_grant2 = 2'b10
	} state_t;

	state_t state;
	state_t next_state;
	// set when port 2 held the last grant
	logic   last_was2;
	logic   pick2;

	// winner among pending requests, used only from idle
	always_comb begin
		pick2 = i_bus_en2;
		if (i_bus_en1 && i_bus_en2) begin
			case (i_prio_mode)
				bus_pkg::prio_port1:       pick2 = 1'b0;
				bus_pkg::prio_round_robin: pick2 = !last_was2;
				default:                   pick2 = 1'b1;
			endcase
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (i_bus_en1 || i_bus_en2) begin
					next_state = pick2 ? st_grant2 : st_grant1;
				end
			end
			st_grant1: begin
				if (!i_bus_en1 && !i_ack) begin
					next_state = st_idle;
				end
			end
			st_grant2: begin
				if (!i_bus_en2 && !i_ack) begin
					next_state = st_idle;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			state     <= st_idle;
			last_was2 <= 1'b1;
		end else begin
			state <= next_state;
			if (state == st_idle && (i_bus_en1 || i_bus_en2)) begin
				last_was2 <= pick2;
			end
		end
	end

	// forward the granted master, everything else stays zero
	always_comb begin
		o_bus_en   = 1'b0;
		o_wr_rd    = 1'b0;
		o_wr_data  = '0;
		o_addr     = '0;
		o_size     = '0;
		o_ack1     = 1'b0;
		o_rd_data1 = '0;
		o_ack2     = 1'b0;
		o_rd_data2 = '0;
		if (state == st_grant1) begin
			o_bus_en   = i_bus_en1;
			o_wr_rd    = i_wr_rd1;
			o_wr_data  = i_wr_data1;
			o_addr     = i_addr1;
			o_size     = i_size1;
			o_ack1     = i_ack;
			o_rd_data1 = i_rd_data;
		end else if (state == st_grant2) begin
			o_bus_en   = i_bus_en2;
			o_wr_rd    = i_wr_rd2;
			o_wr_data  = i_wr_data2;
			o_addr     = i_addr2;
			o_size     = i_size2;
			o_ack2     = i_ack;
			o_rd_data2 = i_rd_data;
		end
	end

endmodule

`default_nettype wire

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// data and address share one width
	localparam int data_w = 32;
	localparam int lanes = data_w / 8;

	// transfer size codes
	localparam int size_w = 3;
	localparam logic [size_w-1:0] size_byte = 3'd0;
	localparam logic [size_w-1:0] size_half = 3'd1;
	localparam logic [size_w-1:0] size_word = 3'd2;

	// word memory, indexed by address bits 9:2
	localparam int mem_words = 256;
	localparam int mem_idx_w = $clog2(mem_words);

	// address map: bit 31 set selects the config block
	localparam int cfg_sel_bit = 31;
	localparam logic [cfg_sel_bit-1:0] cfg_prio_addr = 'h0;
	localparam logic [cfg_sel_bit-1:0] cfg_wait_addr = 'h4;

	// arbitration modes, code 3 falls back to port 2 first
	localparam int prio_w = 2;
	localparam logic [prio_w-1:0] prio_port2 = 2'd0;
	localparam logic [prio_w-1:0] prio_port1 = 2'd1;
	localparam logic [prio_w-1:0] prio_round_robin = 2'd2;

	// memory wait states
	localparam int wait_w = 3;
	localparam logic [wait_w-1:0] wait_reset = 3'd0;

endpackage

`default_nettype wire
